//--- testbench/eth_frames_input.txt
// Columns: payload byte count, payload source, expected FCS
// Source 0 is the digit string, 1 the pangram, 2 the LFSR
// FCS 00000000 marks frames whose FCS comes from the reference model
00000009 00000000 cbf43926
0000002b 00000001 414fa339
0000002e 00000002 00000000
0000003c 00000002 00000000
00000040 00000002 00000000
00000031 00000002 00000000
// End marker
00000000 00000000 00000000

//--- compile.f
verilog/eth_pkg.sv
verilog/mii_pkg.sv
verilog/eth_crc32.sv
verilog/eth_frame_buffer.sv
verilog/eth_tx.sv
verilog/eth_rx.sv
verilog/eth_regs.sv
verilog/eth_core.sv
testbench/eth_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module eth_core_tb \
   -Mdir obj_dir -o eth_core_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/eth_core_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   exit 1
fi

if grep -q "^all tests passed$" sim.log; then
   exit 0
fi
exit 1

//--- testbench/eth_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_core_tb;
   import eth_pkg::*;
   import mii_pkg::*;

   localparam int MAX_FRAMES = 16;
   localparam int MAX_BYTES = 2048;
   localparam logic [ADDR_W-1:0] BUF_BASE = 12'h800;

   logic        clk;
   logic        rst_int;
   cpu_req_t    req;
   cpu_rsp_t    rsp;
   mii_tx_t     mii_tx;
   mii_rx_t     mii_rx;
   logic        phy_resetn;
   logic [3:0]  flip;
   logic [31:0] vec [3*MAX_FRAMES];
   logic [7:0]  payload [MAX_BYTES];
   logic [31:0] lfsr;
   int          cyc = 0;
   int          limit = 1000000;
   mii_tx_t     got [$];
   string       digits = "123456789";
   string       fox = "The quick brown fox jumps over the lazy dog";

   // Loopback with an optional nibble flip for the corrupted frame
   assign mii_rx = '{dv: mii_tx.en, data: mii_tx.data ^ flip};

   eth_core dut_i (
      .clk        (clk),
      .rst_int    (rst_int),
      .req        (req),
      .rsp        (rsp),
      .mii_tx     (mii_tx),
      .mii_rx     (mii_rx),
      .phy_resetn (phy_resetn)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= limit) begin
         report_failure($sformatf("Timeout, run did not finish within %0d cycles", limit));
      end
   end

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_status(input string name, input eth_status_t exp, input eth_status_t act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_nibble(input string name, input mii_tx_t exp, input mii_tx_t act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] next_random_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_step(lfsr);
         b[i] = lfsr[0];
      end
      return b;
   endfunction

   function automatic logic [31:0] bit_reverse(input logic [31:0] v);
      logic [31:0] r;
      for (int i = 0; i < 32; i++) begin
         r[i] = v[31 - i];
      end
      return r;
   endfunction

   // Ethernet FCS in normal bit order over the payload bits as sent
   function automatic logic [31:0] reference_fcs(input int n);
      logic [31:0] c;
      logic [31:0] poly;
      logic        fb;
      c    = CRC_INIT;
      poly = bit_reverse(CRC_POLY);
      for (int i = 0; i < n; i++) begin
         for (int k = 0; k < 8; k++) begin
            fb = c[31] ^ payload[i][k];
            c  = {c[30:0], 1'b0};
            if (fb) begin
               c = c ^ poly;
            end
         end
      end
      return ~bit_reverse(c);
   endfunction

   // Byte i of payload followed by FCS
   function automatic logic [7:0] stream_byte(input int i, input int n, input logic [31:0] fcs);
      if (i < n) begin
         return payload[i];
      end
      return fcs[8*(i-n) +: 8];
   endfunction

   function automatic mii_tx_t expected_nibble(input int idx, input int n, input logic [31:0] fcs);
      logic [7:0] b;
      int         pos;
      pos = idx / 2;
      if (pos < PREAMBLE_LEN) begin
         b = PREAMBLE_BYTE;
      end else if (pos == PREAMBLE_LEN) begin
         b = SFD_BYTE;
      end else begin
         b = stream_byte(pos - PREAMBLE_LEN - 1, n, fcs);
      end
      return '{en: 1'b1, data: (idx % 2) ? b[7:4] : b[3:0]};
   endfunction

   task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic [3:0] wstrb,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int issue_cyc);
      @(posedge clk);
      req.valid <= 1'b1;
      req.wstrb <= wstrb;
      req.addr  <= addr;
      req.wdata <= wdata;
      @(negedge clk);
      issue_cyc = cyc;
      while (!rsp.ready) @(negedge clk);
      check_word("rsp.ready latency", issue_cyc + 1, cyc);
      rdata = rsp.rdata;
      @(posedge clk);
      req.valid <= 1'b0;
      req.wstrb <= 4'h0;
      @(negedge clk);
      while (rsp.ready) @(negedge clk);
   endtask

   task automatic write_reg(input eth_reg_e r, input logic [31:0] data);
      logic [31:0] unused;
      int          issue;
      bus_access({r, 2'b00}, 4'hf, data, unused, issue);
   endtask

   task automatic read_reg(input eth_reg_e r, output logic [31:0] data);
      int issue;
      bus_access({r, 2'b00}, 4'h0, 32'h0, data, issue);
   endtask

   task automatic capture_frame(input int corrupt_at, output int start_cyc);
      got.delete();
      @(negedge clk);
      while (!mii_tx.en) @(negedge clk);
      start_cyc = cyc;
      while (mii_tx.en) begin
         got.push_back(mii_tx);
         if (got.size() == corrupt_at) begin
            @(posedge clk);
            flip <= 4'h4;
         end else if (flip != 4'h0) begin
            @(posedge clk);
            flip <= 4'h0;
         end
         @(negedge clk);
      end
   endtask

   task automatic run_frame(input int n, input int kind, input logic [31:0] file_fcs,
                            input int corrupt_at);
      logic [31:0] word;
      logic [31:0] rd;
      logic [31:0] mask;
      logic [31:0] fcs;
      int          issue;
      int          start;
      eth_status_t exp_st;
      for (int i = 0; i < n; i++) begin
         if (kind == 0) begin
            payload[i] = digits[i % digits.len()];
         end else if (kind == 1) begin
            payload[i] = fox[i % fox.len()];
         end else begin
            payload[i] = next_random_byte();
         end
      end
      fcs = reference_fcs(n);
      if (kind != 2) begin
         check_word("fcs model", file_fcs, fcs);
      end
      write_reg(TX_NBYTES, n);
      for (int w = 0; w < (n + 3) / 4; w++) begin
         word = 32'h0;
         for (int k = 0; k < 4; k++) begin
            if (4*w + k < n) word[8*k +: 8] = payload[4*w + k];
         end
         bus_access(BUF_BASE + 12'(4*w), 4'hf, word, rd, issue);
      end
      fork
         bus_access({SEND, 2'b00}, 4'hf, 32'h1, rd, issue);
         capture_frame(corrupt_at, start);
      join
      check_word("tx_en start", issue + 2, start);
      check_word("tx_en length", 2*n + 24, got.size());
      foreach (got[i]) begin
         check_nibble($sformatf("mii_tx nibble %0d", i), expected_nibble(i, n, fcs), got[i]);
      end
      exp_st              = '0;
      exp_st.tx_ready     = 1'b1;
      exp_st.rx_data_rcvd = 1'b1;
      exp_st.crc_ok       = (corrupt_at == 0);
      exp_st.phy_resetn   = 1'b1;
      exp_st.rcv_size     = NBYTES_W'(n + 4);
      read_reg(STATUS, rd);
      check_status("status", exp_st, rd);
      if (corrupt_at == 0) begin
         read_reg(RCV_SIZE, rd);
         check_word("rcv_size", n + 4, rd);
         for (int w = 0; w < (n + 7) / 4; w++) begin
            word = 32'h0;
            mask = 32'h0;
            for (int k = 0; k < 4; k++) begin
               if (4*w + k < n + 4) begin
                  word[8*k +: 8] = stream_byte(4*w + k, n, fcs);
                  mask[8*k +: 8] = 8'hff;
               end
            end
            bus_access(BUF_BASE + 12'(4*w), 4'h0, 32'h0, rd, issue);
            check_word($sformatf("rx buffer word %0d", w), word, rd & mask);
         end
      end
   endtask

   initial begin
      int          nframes;
      int          nibbles;
      int          release_cyc;
      logic [31:0] rd;
      eth_status_t exp_st;
      eth_status_t st;
      req     = '0;
      rst_int = 1'b1;
      flip    = 4'h0;
      lfsr    = 32'hfe04aead;
      $readmemh("testbench/eth_frames_input.txt", vec);
      nframes = 0;
      nibbles = 2*46 + 24;
      while (nframes < MAX_FRAMES && vec[3*nframes] != 32'h0) begin
         nibbles = nibbles + 2*int'(vec[3*nframes]) + 24;
         nframes++;
      end
      if (nframes == 0) begin
         report_failure("No frames found in the input file");
      end
      limit = 4*nibbles + 2000;
      repeat (8) @(posedge clk);
      rst_int <= 1'b0;
      @(negedge clk);
      release_cyc = cyc;
      check_word("tx_en after reset", 32'h0, 32'(mii_tx.en));

      // Reset values and PHY reset timer
      exp_st          = '0;
      exp_st.tx_ready = 1'b1;
      read_reg(STATUS, rd);
      check_status("status after reset", exp_st, rd);
      read_reg(TX_NBYTES, rd);
      check_word("tx_nbytes", 32'(NBYTES_RESET), rd);
      while (!phy_resetn) @(negedge clk);
      check_word("phy_resetn delay", 32'(PHY_RST_CYCLES) + 1, cyc - release_cyc);

      // Scratch register
      write_reg(DUMMY, 32'ha5c30f1e);
      read_reg(DUMMY, rd);
      check_word("dummy", 32'ha5c30f1e, rd);
      write_reg(DUMMY, 32'h5a3cf0e1);
      read_reg(DUMMY, rd);
      check_word("dummy", 32'h5a3cf0e1, rd);

      // Loopback frames each acknowledged before the next
      for (int f = 0; f < nframes; f++) begin
         run_frame(vec[3*f], vec[3*f + 1], vec[3*f + 2], 0);
         write_reg(RCVACK, 32'h1);
         read_reg(STATUS, rd);
         st = rd;
         check_word("rx_data_rcvd after ack", 32'h0, 32'(st.rx_data_rcvd));
      end

      // Bad payload nibble then soft reset
      run_frame(46, 2, 32'h0, 2*(PREAMBLE_LEN + 1) + 21);
      write_reg(TX_NBYTES, 32'd100);
      read_reg(TX_NBYTES, rd);
      check_word("tx_nbytes", 32'd100, rd);
      write_reg(SOFTRST, 32'h1);
      read_reg(TX_NBYTES, rd);
      check_word("tx_nbytes after soft reset", 32'(NBYTES_RESET), rd);
      read_reg(DUMMY, rd);
      check_word("dummy after soft reset", 32'h0, rd);
      exp_st          = '0;
      exp_st.tx_ready = 1'b1;
      read_reg(STATUS, rd);
      check_status("status after soft reset", exp_st, rd);

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/eth_core.sv
`timescale 1ns/1ps
`default_nettype none

module eth_core (
   input  wire                    clk,
   input  wire                    rst_int,
   input  wire eth_pkg::cpu_req_t req,
   output eth_pkg::cpu_rsp_t      rsp,
   output mii_pkg::mii_tx_t       mii_tx,
   input  wire mii_pkg::mii_rx_t  mii_rx,
   output logic                   phy_resetn
);
   import eth_pkg::*;

   logic                core_rst;
   logic                send;
   logic                rcv_ack;
   logic                tx_wr;
   logic                tx_ready;
   logic                rx_data_rcvd;
   logic                crc_ok;
   logic [NBYTES_W-1:0] tx_nbytes;
   logic [NBYTES_W-1:0] rcv_size;
   logic [BUF_AW-1:0]   tx_rd_addr;
   logic [31:0]         tx_rd_data;
   logic                rx_wr_en;
   logic [BUF_AW-1:0]   rx_wr_addr;
   logic [31:0]         rx_wr_data;
   logic [3:0]          rx_wr_be;
   logic [31:0]         rx_rd_data;
   logic [31:0]         crc;
   eth_status_t         status;

   // phy_resetn is merged in by the register block
   assign status.pad          = '0;
   assign status.rcv_size     = rcv_size;
   assign status.phy_resetn   = 1'b0;
   assign status.crc_ok       = crc_ok;
   assign status.rx_data_rcvd = rx_data_rcvd;
   assign status.tx_ready     = tx_ready;

   eth_regs regs_i (
      .clk        (clk),
      .rst_int    (rst_int),
      .req        (req),
      .rsp        (rsp),
      .core_rst   (core_rst),
      .send       (send),
      .rcv_ack    (rcv_ack),
      .tx_nbytes  (tx_nbytes),
      .tx_wr      (tx_wr),
      .rx_rd_data (rx_rd_data),
      .status     (status),
      .crc        (crc),
      .phy_resetn (phy_resetn)
   );

   eth_frame_buffer tx_buffer (
      .clk    (clk),
      .w_en   (tx_wr),
      .w_addr (req.addr[ADDR_W-2:2]),
      .w_data (req.wdata),
      .w_be   (req.wstrb),
      .r_addr (tx_rd_addr),
      .r_data (tx_rd_data)
   );

   eth_frame_buffer rx_buffer (
      .clk    (clk),
      .w_en   (rx_wr_en),
      .w_addr (rx_wr_addr),
      .w_data (rx_wr_data),
      .w_be   (rx_wr_be),
      .r_addr (req.addr[ADDR_W-2:2]),
      .r_data (rx_rd_data)
   );

   eth_tx tx_i (
      .clk     (clk),
      .rst_int (core_rst),
      .send    (send),
      .nbytes  (tx_nbytes),
      .ready   (tx_ready),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data),
      .mii     (mii_tx)
   );

   eth_rx rx_i (
      .clk       (clk),
      .rst_int   (core_rst),
      .mii       (mii_rx),
      .rcv_ack   (rcv_ack),
      .data_rcvd (rx_data_rcvd),
      .wr_en     (rx_wr_en),
      .wr_addr   (rx_wr_addr),
      .wr_data   (rx_wr_data),
      .wr_be     (rx_wr_be),
      .rcv_size  (rcv_size),
      .crc       (crc),
      .crc_ok    (crc_ok)
   );

endmodule

`default_nettype wire

//--- verilog/eth_regs.sv
`timescale 1ns/1ps
`default_nettype none

module eth_regs (
   input  wire                          clk,
   input  wire                          rst_int,
   input  wire eth_pkg::cpu_req_t       req,
   output eth_pkg::cpu_rsp_t            rsp,
   output logic                         core_rst,
   output logic                         send,
   output logic                         rcv_ack,
   output logic [eth_pkg::NBYTES_W-1:0] tx_nbytes,
   output logic                         tx_wr,
   input  wire [31:0]                   rx_rd_data,
   input  wire eth_pkg::eth_status_t    status,
   input  wire [31:0]                   crc,
   output logic                         phy_resetn
);
   import eth_pkg::*;

   logic                 ready_q;
   logic [31:0]          rdata;
   logic                 wr_cycle;
   logic [REG_AW-1:0]    word_addr;
   logic                 buf_sel;
   logic                 send_en;
   logic                 rcv_ack_en;
   logic                 soft_rst_en;
   logic                 dummy_en;
   logic                 tx_nbytes_en;
   logic                 rx_nbytes_en;
   logic                 soft_rst;
   logic [31:0]          dummy;
   logic [NBYTES_W-1:0]  rx_nbytes;
   logic [PHY_CNT_W-1:0] phy_cnt;
   eth_status_t          status_word;

   assign buf_sel   = req.addr[ADDR_W-1];
   assign word_addr = req.addr[ADDR_W-1:2];

   // Only the first cycle of a held request writes
   assign wr_cycle = req.valid && (|req.wstrb) && !ready_q;

   always_comb begin
      send_en      = 1'b0;
      rcv_ack_en   = 1'b0;
      soft_rst_en  = 1'b0;
      dummy_en     = 1'b0;
      tx_nbytes_en = 1'b0;
      rx_nbytes_en = 1'b0;
      tx_wr        = 1'b0;
      if (wr_cycle) begin
         case (word_addr)
            SEND:      send_en = 1'b1;
            RCVACK:    rcv_ack_en = 1'b1;
            DUMMY:     dummy_en = 1'b1;
            TX_NBYTES: tx_nbytes_en = 1'b1;
            RX_NBYTES: rx_nbytes_en = 1'b1;
            SOFTRST:   soft_rst_en = 1'b1;
            default:   tx_wr = buf_sel;
         endcase
      end
   end

   always_comb begin
      status_word            = status;
      status_word.phy_resetn = phy_resetn;
      case (word_addr)
         STATUS:    rdata = status_word;
         DUMMY:     rdata = dummy;
         TX_NBYTES: rdata = 32'(tx_nbytes);
         RX_NBYTES: rdata = 32'(rx_nbytes);
         CRC:       rdata = crc;
         RCV_SIZE:  rdata = 32'(status.rcv_size);
         default:   rdata = buf_sel ? rx_rd_data : 32'd0;
      endcase
   end

   assign rsp = '{ready: ready_q, rdata: rdata};

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready_q  <= 1'b0;
         soft_rst <= 1'b0;
      end else begin
         ready_q  <= req.valid;
         soft_rst <= soft_rst_en;
      end
   end

   assign core_rst = rst_int || soft_rst;

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         send      <= 1'b0;
         rcv_ack   <= 1'b0;
         dummy     <= '0;
         tx_nbytes <= NBYTES_RESET;
         rx_nbytes <= NBYTES_RESET;
      end else begin
         send    <= send_en;
         rcv_ack <= rcv_ack_en;
         if (dummy_en) begin
            dummy <= req.wdata;
         end
         if (tx_nbytes_en) begin
            tx_nbytes <= req.wdata[NBYTES_W-1:0];
         end
         if (rx_nbytes_en) begin
            rx_nbytes <= req.wdata[NBYTES_W-1:0];
         end
      end
   end

   // PHY held in reset until the counter runs out
   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (phy_cnt != PHY_RST_CYCLES) begin
         phy_cnt <= phy_cnt + 1'b1;
      end else begin
         phy_resetn <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/eth_rx.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx (
   input  wire                          clk,
   input  wire                          rst_int,
   input  wire mii_pkg::mii_rx_t        mii,
   input  wire                          rcv_ack,
   output logic                         data_rcvd,
   output logic                         wr_en,
   output logic [eth_pkg::BUF_AW-1:0]   wr_addr,
   output logic [31:0]                  wr_data,
   output logic [3:0]                   wr_be,
   output logic [eth_pkg::NBYTES_W-1:0] rcv_size,
   output logic [31:0]                  crc,
   output logic                         crc_ok
);
   import eth_pkg::*;
   import mii_pkg::*;

   rx_state_e           state;
   logic                phase;
   logic [3:0]          last_nib;
   logic [7:0]          rx_byte;
   logic                sfd_seen;
   logic                byte_done;
   logic [NBYTES_W-1:0] byte_cnt;
   logic [1:0]          lane;

   // Current nibble on top of the previous one
   assign rx_byte   = {mii.data, last_nib};
   assign sfd_seen  = (state == RX_PREAMBLE) && mii.dv && (rx_byte == SFD_BYTE);
   assign byte_done = (state == RX_PAYLOAD) && mii.dv && phase;
   assign lane      = byte_cnt[1:0];

   assign data_rcvd = (state == RX_DONE);
   assign rcv_size  = byte_cnt;

   // A good frame leaves the residue in the raw register
   assign crc_ok = (crc == CRC_RESIDUE);

   eth_crc32 crc_i (
      .clk     (clk),
      .rst_int (rst_int),
      .init    (sfd_seen),
      .en      (byte_done),
      .data    (rx_byte),
      .crc     (crc)
   );

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state    <= RX_IDLE;
         phase    <= 1'b0;
         byte_cnt <= '0;
         wr_en    <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (mii.dv) begin
                  state <= RX_PREAMBLE;
               end
            end
            RX_PREAMBLE: begin
               if (!mii.dv) begin
                  state <= RX_IDLE;
               end else if (sfd_seen) begin
                  state    <= RX_PAYLOAD;
                  phase    <= 1'b0;
                  byte_cnt <= '0;
               end
            end
            RX_PAYLOAD: begin
               if (!mii.dv) begin
                  // Flush a partly filled word
                  state <= RX_DONE;
                  wr_en <= (lane != 2'd0);
               end else begin
                  phase <= ~phase;
                  if (phase) begin
                     byte_cnt <= byte_cnt + 1'b1;
                     wr_en    <= (lane == 2'd3);
                  end
               end
            end
            RX_DONE: begin
               if (rcv_ack) begin
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Word assembly, lanes enabled as they fill
   always_ff @(posedge clk) begin
      last_nib <= mii.data;
      if (byte_done) begin
         wr_data[8*lane +: 8] <= rx_byte;
         wr_be   <= (lane == 2'd0) ? 4'b0001 : (wr_be | (4'b0001 << lane));
         wr_addr <= byte_cnt[NBYTES_W-1:2];
      end
   end

endmodule

`default_nettype wire

//--- verilog/eth_tx.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx (
   input  wire                          clk,
   input  wire                          rst_int,
   input  wire                          send,
   input  wire [eth_pkg::NBYTES_W-1:0]  nbytes,
   output logic                         ready,
   output logic [eth_pkg::BUF_AW-1:0]   rd_addr,
   input  wire [31:0]                   rd_data,
   output mii_pkg::mii_tx_t             mii
);
   import eth_pkg::*;
   import mii_pkg::*;

   tx_state_e           state;
   logic                phase;
   logic [NBYTES_W-1:0] byte_cnt;
   logic [1:0]          lane_d;
   logic                en_d;
   logic [7:0]          buf_byte;
   logic [7:0]          fcs_byte;
   logic [7:0]          tx_byte;
   logic                crc_init;
   logic                crc_en;
   logic [31:0]         crc;

   // byte_cnt points at the byte that shows up on rd_data next cycle
   assign rd_addr  = byte_cnt[NBYTES_W-1:2];
   assign buf_byte = rd_data[8*lane_d +: 8];
   assign fcs_byte = ~crc[8*byte_cnt[1:0] +: 8];

   always_comb begin
      case (state)
         TX_PREAMBLE: tx_byte = PREAMBLE_BYTE;
         TX_SFD:      tx_byte = SFD_BYTE;
         TX_PAYLOAD:  tx_byte = buf_byte;
         TX_FCS:      tx_byte = fcs_byte;
         default:     tx_byte = 8'h00;
      endcase
   end

   // Low nibble goes out first
   assign mii.en   = (state != TX_IDLE);
   assign mii.data = phase ? tx_byte[7:4] : tx_byte[3:0];

   // Stays low for one more cycle after tx_en drops
   assign ready = (state == TX_IDLE) && !en_d;

   assign crc_init = (state == TX_IDLE);
   assign crc_en   = (state == TX_PAYLOAD) && !phase;

   eth_crc32 crc_i (
      .clk     (clk),
      .rst_int (rst_int),
      .init    (crc_init),
      .en      (crc_en),
      .data    (buf_byte),
      .crc     (crc)
   );

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state    <= TX_IDLE;
         phase    <= 1'b0;
         byte_cnt <= '0;
         lane_d   <= 2'd0;
         en_d     <= 1'b0;
      end else begin
         lane_d <= byte_cnt[1:0];
         en_d   <= mii.en;
         phase  <= (state == TX_IDLE) ? 1'b0 : ~phase;
         case (state)
            TX_IDLE: begin
               byte_cnt <= '0;
               if (send && ready) begin
                  state <= TX_PREAMBLE;
               end
            end
            TX_PREAMBLE: begin
               if (phase && byte_cnt == NBYTES_W'(PREAMBLE_LEN - 1)) begin
                  byte_cnt <= '0;
                  state    <= TX_SFD;
               end else if (phase) begin
                  byte_cnt <= byte_cnt + 1'b1;
               end
            end
            TX_SFD: begin
               if (phase) begin
                  state <= TX_PAYLOAD;
               end
            end
            TX_PAYLOAD: begin
               // Step ahead on the low nibble so the next word is fetched in time
               if (!phase) begin
                  byte_cnt <= byte_cnt + 1'b1;
               end else if (byte_cnt == nbytes) begin
                  byte_cnt <= '0;
                  state    <= TX_FCS;
               end
            end
            TX_FCS: begin
               if (phase) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt[1:0] == 2'(FCS_LEN - 1)) begin
                     state <= TX_IDLE;
                  end
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/eth_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module eth_frame_buffer (
   input  wire                        clk,
   input  wire                        w_en,
   input  wire [eth_pkg::BUF_AW-1:0]  w_addr,
   input  wire [31:0]                 w_data,
   input  wire [3:0]                  w_be,
   input  wire [eth_pkg::BUF_AW-1:0]  r_addr,
   output logic [31:0]                r_data
);
   import eth_pkg::*;

   logic [31:0] mem [2**BUF_AW];

   // Byte lane writes, read data one cycle after the address
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (w_en && w_be[i]) begin
            mem[w_addr][8*i +: 8] <= w_data[8*i +: 8];
         end
      end
      r_data <= mem[r_addr];
   end

endmodule

`default_nettype wire

//--- verilog/eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
   input  wire        clk,
   input  wire        rst_int,
   input  wire        init,
   input  wire        en,
   input  wire [7:0]  data,
   output logic [31:0] crc
);
   import mii_pkg::*;

   logic [31:0] crc_next;

   // One byte per step, LSB first as it goes on the wire
   always_comb begin
      crc_next = crc;
      for (int i = 0; i < 8; i++) begin
         if (crc_next[0] ^ data[i]) begin
            crc_next = (crc_next >> 1) ^ CRC_POLY;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         crc <= CRC_INIT;
      end else if (init) begin
         crc <= CRC_INIT;
      end else if (en) begin
         crc <= crc_next;
      end
   end

endmodule

`default_nettype wire

//--- verilog/mii_pkg.sv
`default_nettype none

package mii_pkg;

   typedef struct packed {
      logic       en;
      logic [3:0] data;
   } mii_tx_t;

   typedef struct packed {
      logic       dv;
      logic [3:0] data;
   } mii_rx_t;

   // Frame fields
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE = 8'hD5;
   localparam int PREAMBLE_LEN = 7;
   localparam int FCS_LEN = 4;

   // Reflected CRC-32
   localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;
   localparam logic [31:0] CRC_POLY = 32'hEDB88320;
   localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_SFD,
      TX_PAYLOAD,
      TX_FCS
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_PAYLOAD,
      RX_DONE
   } rx_state_e;

endpackage

`default_nettype wire

//--- verilog/eth_pkg.sv
`default_nettype none

package eth_pkg;

   // CPU address map, byte addressed
   localparam int ADDR_W = 12;
   localparam int REG_AW = ADDR_W - 2;

   // Frame buffer geometry
   localparam int BUF_AW = 9;
   localparam int NBYTES_W = 11;
   localparam logic [NBYTES_W-1:0] NBYTES_RESET = 11'd46;

   // PHY reset hold time
   localparam int PHY_CNT_W = 8;
   localparam logic [PHY_CNT_W-1:0] PHY_RST_CYCLES = 8'd255;

   // Register word addresses, buffers sit at bit 11 and above
   typedef enum logic [REG_AW-1:0] {
      STATUS    = REG_AW'(0),
      SEND      = REG_AW'(1),
      RCVACK    = REG_AW'(2),
      DUMMY     = REG_AW'(3),
      TX_NBYTES = REG_AW'(4),
      RX_NBYTES = REG_AW'(5),
      CRC       = REG_AW'(6),
      RCV_SIZE  = REG_AW'(7),
      SOFTRST   = REG_AW'(8)
   } eth_reg_e;

   typedef struct packed {
      logic              valid;
      logic [3:0]        wstrb;
      logic [ADDR_W-1:0] addr;
      logic [31:0]       wdata;
   } cpu_req_t;

   typedef struct packed {
      logic        ready;
      logic [31:0] rdata;
   } cpu_rsp_t;

   // Low bit is tx_ready
   typedef struct packed {
      logic [16:0]         pad;
      logic [NBYTES_W-1:0] rcv_size;
      logic                phy_resetn;
      logic                crc_ok;
      logic                rx_data_rcvd;
      logic                tx_ready;
   } eth_status_t;

endpackage

`default_nettype wire
